// File: periph_pkg.sv
////////////////////////////////////////////////////////////
// peripheral bus types and map
////////////////////////////////////////////////////////////

package periph_pkg;

    // widths with a meaning on the bus
    typedef logic [10:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [7:0]  byte_t;
    typedef logic [1:0]  access_t;

    // bit 4 picks the byte slots, bits 3:0 the slot number
    typedef logic [4:0]  func_sel_t;

    // 11 none, 00 byte, 01 halfword, 10 word
    localparam access_t ACCESS_NONE = 2'b11;

    // address bits 10:9 of the byte slot space
    localparam logic [1:0] BYTE_SPACE = 2'b10;

    localparam logic [3:0] SLOT_GPIO = 4'd1;
    localparam logic [3:0] SLOT_EDGE = 4'd1;

    localparam int NUM_PINS = 8;

    // gpio register offsets within its 64 byte slot
    localparam logic [5:0] GPIO_REG_OUT       = 6'h00;
    localparam logic [5:0] GPIO_REG_IN        = 6'h04;
    localparam logic [5:0] GPIO_REG_FUNC_BASE = 6'h20;

    // edge counter registers within its 16 byte slot
    localparam logic [3:0] EDGE_REG_PIN   = 4'd0;
    localparam logic [3:0] EDGE_REG_COUNT = 4'd1;

    typedef struct packed {
        addr_t   address;
        word_t   wdata;
        access_t write_n;
        access_t read_n;
    } periph_req_t;

    typedef struct packed {
        word_t rdata;
        logic  ready;
    } periph_rsp_t;

endpackage

// File: periph_bus.sv
////////////////////////////////////////////////////////////
// peripheral bus decode and read buffer
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module periph_bus (
    input  logic                    clk,
    input  logic                    rst_n,
    input  periph_pkg::periph_req_t i_req,
    input  periph_pkg::periph_rsp_t i_gpio_rsp,
    input  periph_pkg::byte_t       i_edge_rdata,
    input  logic                    i_read_complete,
    output periph_pkg::periph_req_t o_gpio_req,
    output periph_pkg::periph_req_t o_edge_req,
    output periph_pkg::word_t       o_data_out,
    output logic                    o_data_ready
);

    logic              byte_space;
    logic              full_space;
    logic              gpio_sel;
    logic              edge_sel;
    logic              read_req;
    logic              write_req;

    periph_pkg::word_t src_data;
    logic              src_ready;

    // read buffer state
    periph_pkg::word_t data_out_r;
    logic              data_hold;
    logic              data_ready_r;

    // only the selected peripheral sees the access,
    // and no peripheral sees a read while a result is held
    function automatic periph_pkg::periph_req_t gate_req(
        input periph_pkg::periph_req_t req,
        input logic                    sel,
        input logic                    mask_read
    );
        periph_pkg::periph_req_t gated;
        gated = req;
        if (!sel) begin
            gated.write_n = periph_pkg::ACCESS_NONE;
            gated.read_n  = periph_pkg::ACCESS_NONE;
        end else if (mask_read) begin
            gated.read_n = periph_pkg::ACCESS_NONE;
        end
        return gated;
    endfunction

    // address decode
    assign byte_space = (i_req.address[10:9] == periph_pkg::BYTE_SPACE);
    assign full_space = !i_req.address[10];

    assign gpio_sel = full_space && (i_req.address[9:6] == periph_pkg::SLOT_GPIO);
    assign edge_sel = byte_space && (i_req.address[7:4] == periph_pkg::SLOT_EDGE);

    assign read_req  = (i_req.read_n != periph_pkg::ACCESS_NONE);
    assign write_req = (i_req.write_n != periph_pkg::ACCESS_NONE);

    assign o_gpio_req = gate_req(i_req, gpio_sel, data_hold);
    assign o_edge_req = gate_req(i_req, edge_sel, data_hold);

    // response mux, empty slots read zero and are ready at once
    always_comb begin
        src_data  = '0;
        src_ready = 1'b1;
        if (gpio_sel) begin
            src_data  = i_gpio_rsp.rdata;
            src_ready = i_gpio_rsp.ready;
        end else if (edge_sel) begin
            src_data = {24'h0, i_edge_rdata};
        end
    end

    // capture once per read, hold until the core says it is done
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            data_hold    <= 1'b0;
            data_ready_r <= 1'b0;
        end else begin
            if (i_read_complete) begin
                data_hold <= 1'b0;
            end
            if (!data_hold && src_ready && read_req) begin
                data_hold <= 1'b1;
            end
            data_ready_r <= read_req && src_ready;
        end
    end

    always_ff @(posedge clk) begin
        if (!data_hold && src_ready && read_req) begin
            data_out_r <= src_data;
        end
    end

    assign o_data_out   = data_out_r;
    // writes complete in the same cycle
    assign o_data_ready = data_ready_r || write_req;

endmodule

// File: gpio_ctrl.sv
////////////////////////////////////////////////////////////
// gpio registers and output pin mux
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module gpio_ctrl (
    input  logic                    clk,
    input  logic                    rst_n,
    input  periph_pkg::periph_req_t i_req,
    input  periph_pkg::byte_t       i_ui_in,
    input  periph_pkg::byte_t       i_edge_pins,
    output periph_pkg::periph_rsp_t o_rsp,
    output periph_pkg::byte_t       o_uo_out
);

    localparam int IDX_W = $clog2(periph_pkg::NUM_PINS);

    logic [5:0]            offset;
    logic                  wr_en;
    logic                  func_hit;
    logic [IDX_W-1:0]      func_idx;

    periph_pkg::byte_t     gpio_out;
    periph_pkg::func_sel_t func_sel [periph_pkg::NUM_PINS];
    periph_pkg::word_t     rdata;

    // request is already gated to this slot by the bus
    assign offset = i_req.address[5:0];
    assign wr_en  = (i_req.write_n != periph_pkg::ACCESS_NONE);

    // one word per pin from 0x20 up to 0x3c
    assign func_hit = ({offset[5], offset[1:0]} ==
                       {periph_pkg::GPIO_REG_FUNC_BASE[5], periph_pkg::GPIO_REG_FUNC_BASE[1:0]});
    assign func_idx = offset[IDX_W+1:2];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            gpio_out <= '0;
        end else if (wr_en && offset == periph_pkg::GPIO_REG_OUT) begin
            gpio_out <= i_req.wdata[7:0];
        end
    end

    // every pin starts out driven by the gpio output register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < periph_pkg::NUM_PINS; i++) begin
                func_sel[i] <= {1'b0, periph_pkg::SLOT_GPIO};
            end
        end else if (wr_en && func_hit) begin
            func_sel[func_idx] <= i_req.wdata[4:0];
        end
    end

    // register readback
    always_comb begin
        rdata = '0;
        if (offset == periph_pkg::GPIO_REG_OUT) begin
            rdata = {24'h0, gpio_out};
        end else if (offset == periph_pkg::GPIO_REG_IN) begin
            rdata = {24'h0, i_ui_in};
        end else if (func_hit) begin
            rdata = {27'h0, func_sel[func_idx]};
        end
    end

    assign o_rsp.rdata = rdata;
    assign o_rsp.ready = 1'b1;

    // per pin source select, unused slots drive zero
    always_comb begin
        for (int i = 0; i < periph_pkg::NUM_PINS; i++) begin
            o_uo_out[i] = 1'b0;
            if (!func_sel[i][4] && func_sel[i][3:0] == periph_pkg::SLOT_GPIO) begin
                o_uo_out[i] = gpio_out[i];
            end else if (func_sel[i][4] && func_sel[i][3:0] == periph_pkg::SLOT_EDGE) begin
                o_uo_out[i] = i_edge_pins[i];
            end
        end
    end

endmodule

// File: edge_counter.sv
////////////////////////////////////////////////////////////
// rising edge counter, byte slot
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module edge_counter (
    input  logic                    clk,
    input  logic                    rst_n,
    input  periph_pkg::periph_req_t i_req,
    input  periph_pkg::byte_t       i_ui_in,
    output periph_pkg::byte_t       o_rdata,
    output periph_pkg::byte_t       o_pins
);

    logic [3:0]        reg_addr;
    logic              wr_en;
    logic [2:0]        pin_sel;
    logic              pin_now;
    logic              pin_prev;
    logic              rise;
    periph_pkg::byte_t count;

    assign reg_addr = i_req.address[3:0];
    assign wr_en    = (i_req.write_n != periph_pkg::ACCESS_NONE);

    assign pin_now = i_ui_in[pin_sel];
    assign rise    = pin_now && !pin_prev;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pin_sel <= '0;
        end else if (wr_en && reg_addr == periph_pkg::EDGE_REG_PIN) begin
            pin_sel <= i_req.wdata[2:0];
        end
    end

    // previous sample of the watched pin
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pin_prev <= 1'b0;
        end else begin
            pin_prev <= pin_now;
        end
    end

    // a write to the count register clears it, otherwise wrap on overflow
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count <= '0;
        end else if (wr_en && reg_addr == periph_pkg::EDGE_REG_COUNT) begin
            count <= '0;
        end else if (rise) begin
            count <= count + 8'd1;
        end
    end

    always_comb begin
        o_rdata = '0;
        case (reg_addr)
            periph_pkg::EDGE_REG_PIN:   o_rdata = {5'h0, pin_sel};
            periph_pkg::EDGE_REG_COUNT: o_rdata = count;
            default:                    o_rdata = '0;
        endcase
    end

    assign o_pins = count;

endmodule

// File: periph_top.sv
////////////////////////////////////////////////////////////
// peripheral wrapper top
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module periph_top (
    input  logic                    clk,
    input  logic                    rst_n,
    input  periph_pkg::byte_t       i_ui_in,
    input  periph_pkg::periph_req_t i_req,
    input  logic                    i_read_complete,
    output periph_pkg::byte_t       o_uo_out,
    output periph_pkg::word_t       o_data_out,
    output logic                    o_data_ready
);

    // gated requests from the bus
    periph_pkg::periph_req_t gpio_req;
    periph_pkg::periph_req_t edge_req;

    periph_pkg::periph_rsp_t gpio_rsp;
    periph_pkg::byte_t       edge_rdata;

    // edge counter pins, routed out through the gpio mux
    periph_pkg::byte_t       edge_pins;

    periph_bus u_bus (
        .clk             (clk),
        .rst_n           (rst_n),
        .i_req           (i_req),
        .i_gpio_rsp      (gpio_rsp),
        .i_edge_rdata    (edge_rdata),
        .i_read_complete (i_read_complete),
        .o_gpio_req      (gpio_req),
        .o_edge_req      (edge_req),
        .o_data_out      (o_data_out),
        .o_data_ready    (o_data_ready)
    );

    gpio_ctrl u_gpio (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_req       (gpio_req),
        .i_ui_in     (i_ui_in),
        .i_edge_pins (edge_pins),
        .o_rsp       (gpio_rsp),
        .o_uo_out    (o_uo_out)
    );

    edge_counter u_edge (
        .clk     (clk),
        .rst_n   (rst_n),
        .i_req   (edge_req),
        .i_ui_in (i_ui_in),
        .o_rdata (edge_rdata),
        .o_pins  (edge_pins)
    );

endmodule

// File: periph_chk.sv
////////////////////////////////////////////////////////////
// read buffer protocol assertions
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module periph_chk (
    input logic                    clk,
    input logic                    rst_n,
    input periph_pkg::periph_req_t i_req,
    input logic                    i_read_complete,
    input periph_pkg::word_t       i_data_out,
    input logic                    i_data_ready,
    input logic                    i_data_hold,
    input logic                    i_data_ready_r
);

    logic read_req;

    assign read_req = (i_req.read_n != periph_pkg::ACCESS_NONE);

    ready_after_reset: assert property (@(posedge clk) !rst_n |=> !i_data_ready)
        else $error("data ready high in the cycle after reset");

    // held result must not move until the core is done with it
    hold_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (i_data_hold && !i_read_complete) |=> $stable(i_data_out))
        else $error("read data changed while held");

    ready_needs_read: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(i_data_ready_r) |-> $past(read_req))
        else $error("registered ready rose without a read request");

endmodule

// File: tb_periph.sv
////////////////////////////////////////////////////////////
// peripheral wrapper testbench
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module tb_periph;

    // cycle budget of each test, the watchdog allows four times the sum
    localparam int CYC_SETUP  = 20;
    localparam int CYC_RESET  = 60;
    localparam int CYC_GPIO   = 100;
    localparam int CYC_SELECT = 620;
    localparam int CYC_EDGE   = 3400;
    localparam int CYC_HOLD   = 160;
    localparam int CYC_EMPTY  = 260;
    localparam int TOTAL_CYCLES = CYC_SETUP + CYC_RESET + CYC_GPIO + CYC_SELECT
                                  + CYC_EDGE + CYC_HOLD + CYC_EMPTY;
    localparam int READ_LIMIT = 20;
    localparam periph_pkg::access_t ACCESS_WORD = 2'b10;

    logic                    clk;
    logic                    rst_n;
    periph_pkg::byte_t       ui_in;
    periph_pkg::periph_req_t req;
    logic                    read_complete;
    periph_pkg::byte_t       uo_out;
    periph_pkg::word_t       data_out;
    logic                    data_ready;

    logic [15:0] lfsr = 16'd30;
    int          pass_count = 0;
    int          fail_count = 0;
    int          fails_before = 0;
    string       cur_test = "setup";

    // checks waiting for the compare process
    string             name_q[$];
    periph_pkg::word_t exp_q[$];
    periph_pkg::word_t act_q[$];

    // register state of the model
    periph_pkg::byte_t     m_gpio_out = '0;
    periph_pkg::func_sel_t m_sel [8];
    logic [2:0]            m_edge_pin = '0;
    periph_pkg::byte_t     m_edge_count = '0;

    periph_top uut (
        .clk             (clk),
        .rst_n           (rst_n),
        .i_ui_in         (ui_in),
        .i_req           (req),
        .i_read_complete (read_complete),
        .o_uo_out        (uo_out),
        .o_data_out      (data_out),
        .o_data_ready    (data_ready)
    );

    bind periph_bus periph_chk u_chk (
        .clk             (clk),
        .rst_n           (rst_n),
        .i_req           (i_req),
        .i_read_complete (i_read_complete),
        .i_data_out      (o_data_out),
        .i_data_ready    (o_data_ready),
        .i_data_hold     (data_hold),
        .i_data_ready_r  (data_ready_r)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // 40 ns per cycle
    initial begin
        #(TOTAL_CYCLES * 40 * 4);
        $display("run timed out after %0d cycles before the tests finished", TOTAL_CYCLES * 4);
        $display("Verification failed");
        $finish;
    end

    // taps 16 14 13 11, one step per bit
    function automatic periph_pkg::word_t rand_bits(input int n);
        periph_pkg::word_t r;
        r = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic periph_pkg::byte_t rand_byte();
        periph_pkg::word_t w;
        w = rand_bits(8);
        return w[7:0];
    endfunction

    function automatic periph_pkg::addr_t full_addr(input logic [3:0] slot, input logic [5:0] off);
        return {1'b0, slot, off};
    endfunction

    function automatic periph_pkg::addr_t byte_addr(input logic [3:0] slot, input logic [3:0] r);
        return {2'b10, 1'b0, slot, r};
    endfunction

    function automatic logic [5:0] func_off(input logic [2:0] pin);
        return periph_pkg::GPIO_REG_FUNC_BASE | {1'b0, pin, 2'b00};
    endfunction

    // model update for a write, unmapped and empty slots change nothing
    function automatic void apply_write(input periph_pkg::addr_t addr, input periph_pkg::word_t data);
        if (addr[10:9] == 2'b10 && addr[7:4] == periph_pkg::SLOT_EDGE) begin
            if (addr[3:0] == periph_pkg::EDGE_REG_PIN)
                m_edge_pin = data[2:0];
            else if (addr[3:0] == periph_pkg::EDGE_REG_COUNT)
                m_edge_count = '0;
        end else if (!addr[10] && addr[9:6] == periph_pkg::SLOT_GPIO) begin
            if (addr[5:0] == periph_pkg::GPIO_REG_OUT)
                m_gpio_out = data[7:0];
            else if (addr[5] && addr[1:0] == 2'b00)
                m_sel[addr[4:2]] = data[4:0];
        end
    endfunction

    // expected read data for an address, given the input port
    function automatic periph_pkg::word_t read_expect(input periph_pkg::addr_t addr,
                                                      input periph_pkg::byte_t ui);
        periph_pkg::word_t r;
        r = '0;
        if (addr[10:9] == 2'b10 && addr[7:4] == periph_pkg::SLOT_EDGE) begin
            if (addr[3:0] == periph_pkg::EDGE_REG_PIN)
                r = {29'h0, m_edge_pin};
            else if (addr[3:0] == periph_pkg::EDGE_REG_COUNT)
                r = {24'h0, m_edge_count};
        end else if (!addr[10] && addr[9:6] == periph_pkg::SLOT_GPIO) begin
            if (addr[5:0] == periph_pkg::GPIO_REG_OUT)
                r = {24'h0, m_gpio_out};
            else if (addr[5:0] == periph_pkg::GPIO_REG_IN)
                r = {24'h0, ui};
            else if (addr[5] && addr[1:0] == 2'b00)
                r = {27'h0, m_sel[addr[4:2]]};
        end
        return r;
    endfunction

    function automatic periph_pkg::byte_t pins_expect();
        periph_pkg::byte_t p;
        p = '0;
        for (int i = 0; i < 8; i++) begin
            if (m_sel[i] == {1'b0, periph_pkg::SLOT_GPIO})
                p[i] = m_gpio_out[i];
            else if (m_sel[i] == {1'b1, periph_pkg::SLOT_EDGE})
                p[i] = m_edge_count[i];
        end
        return p;
    endfunction

    task automatic compare(input string name, input periph_pkg::word_t expected,
                           input periph_pkg::word_t actual);
        if (expected !== actual) begin
            $display("ERROR %s: expected %h, actual %h", name, expected, actual);
            fail_count++;
        end else begin
            pass_count++;
        end
    endtask

    task automatic push_check(input string name, input periph_pkg::word_t expected,
                              input periph_pkg::word_t actual);
        name_q.push_back({cur_test, ": ", name});
        exp_q.push_back(expected);
        act_q.push_back(actual);
    endtask

    // compare process
    initial begin
        forever begin
            @(negedge clk);
            while (name_q.size() > 0)
                compare(name_q.pop_front(), exp_q.pop_front(), act_q.pop_front());
        end
    end

    task automatic write_reg(input periph_pkg::addr_t addr, input periph_pkg::word_t data);
        @(posedge clk);
        #2;
        req.address = addr;
        req.wdata   = data;
        req.write_n = ACCESS_WORD;
        // writes are acknowledged in their own cycle
        @(negedge clk);
        push_check("write ready", 32'h1, {31'h0, data_ready});
        @(posedge clk);
        #2;
        req.write_n = periph_pkg::ACCESS_NONE;
        apply_write(addr, data);
    endtask

    task automatic start_read(input periph_pkg::addr_t addr, output periph_pkg::word_t data);
        int waited;
        waited = 0;
        @(posedge clk);
        #2;
        req.address = addr;
        req.read_n  = ACCESS_WORD;
        do begin
            @(posedge clk);
            #2;
            waited++;
        end while (!data_ready && waited < READ_LIMIT);
        if (!data_ready) begin
            $display("read at address %h got no ready within %0d cycles", addr, READ_LIMIT);
            fail_count++;
        end else begin
            push_check("ready latency", 32'h1, waited);
        end
        data = data_out;
    endtask

    task automatic finish_read();
        read_complete = 1'b1;
        @(posedge clk);
        #2;
        read_complete = 1'b0;
        req.read_n    = periph_pkg::ACCESS_NONE;
    endtask

    task automatic read_check(input string name, input periph_pkg::addr_t addr,
                              input periph_pkg::word_t expected);
        periph_pkg::word_t got;
        start_read(addr, got);
        finish_read();
        push_check(name, expected, got);
    endtask

    // one cycle of random input with the watched pin forced
    task automatic drive_pin(input logic [2:0] pin, input logic level);
        @(posedge clk);
        #2;
        ui_in = rand_byte();
        ui_in[pin] = level;
    endtask

    task automatic report_test();
        repeat (2) @(posedge clk);
        if (fail_count == fails_before)
            $display("test %s: ok", cur_test);
        else
            $display("test %s: %0d failed checks", cur_test, fail_count - fails_before);
        fails_before = fail_count;
        #2;
    endtask

    initial begin
        periph_pkg::word_t     w;
        periph_pkg::word_t     d;
        periph_pkg::word_t     want;
        periph_pkg::func_sel_t sel;
        logic [2:0]            pin;
        periph_pkg::addr_t     a;

        rst_n         = 1'b0;
        ui_in         = '0;
        read_complete = 1'b0;
        req           = '0;
        req.write_n   = periph_pkg::ACCESS_NONE;
        req.read_n    = periph_pkg::ACCESS_NONE;
        for (int i = 0; i < 8; i++)
            m_sel[i] = {1'b0, periph_pkg::SLOT_GPIO};
        repeat (10) @(posedge clk);
        #2;
        rst_n = 1'b1;
        repeat (2) @(posedge clk);
        #2;

        cur_test = "reset values";
        push_check("uo_out", 32'h0, {24'h0, uo_out});
        read_check("gpio out", full_addr(periph_pkg::SLOT_GPIO, periph_pkg::GPIO_REG_OUT), 32'h0);
        for (int i = 0; i < 8; i++)
            read_check("func sel", full_addr(periph_pkg::SLOT_GPIO, func_off(3'(i))), 32'h1);
        report_test();

        cur_test = "gpio out and in";
        repeat (6) begin
            a = full_addr(periph_pkg::SLOT_GPIO, periph_pkg::GPIO_REG_OUT);
            write_reg(a, rand_bits(32));
            push_check("uo_out after write", {24'h0, pins_expect()}, {24'h0, uo_out});
            read_check("out readback", a, read_expect(a, ui_in));
            ui_in = rand_byte();
            a = full_addr(periph_pkg::SLOT_GPIO, periph_pkg::GPIO_REG_IN);
            read_check("in readback", a, read_expect(a, ui_in));
        end
        report_test();

        cur_test = "function select";
        // a nonzero count so pins on the edge counter differ from empty slots
        ui_in = '0;
        write_reg(byte_addr(periph_pkg::SLOT_EDGE, periph_pkg::EDGE_REG_COUNT), 32'h0);
        w = rand_bits(8);
        repeat (w[7:0] | 8'h01) begin
            drive_pin(m_edge_pin, 1'b1);
            drive_pin(m_edge_pin, 1'b0);
            m_edge_count = m_edge_count + 8'd1;
        end
        write_reg(full_addr(periph_pkg::SLOT_GPIO, periph_pkg::GPIO_REG_OUT), rand_bits(32));
        for (int i = 0; i < 8; i++) begin
            // mostly the two live sources, sometimes any select
            w = rand_bits(7);
            sel = w[4:0];
            if (w[6:5] == 2'd0)
                sel = {1'b0, periph_pkg::SLOT_GPIO};
            else if (w[6:5] == 2'd1)
                sel = {1'b1, periph_pkg::SLOT_EDGE};
            d = rand_bits(32);
            d[4:0] = sel;
            a = full_addr(periph_pkg::SLOT_GPIO, func_off(3'(i)));
            write_reg(a, d);
            push_check("uo_out", {24'h0, pins_expect()}, {24'h0, uo_out});
            read_check("select readback", a, read_expect(a, ui_in));
        end
        report_test();

        cur_test = "edge counter";
        ui_in = '0;
        for (int i = 0; i < 8; i++)
            write_reg(full_addr(periph_pkg::SLOT_GPIO, func_off(3'(i))),
                      {27'h0, 1'b1, periph_pkg::SLOT_EDGE});
        repeat (3) begin
            // all inputs low so a new pin index sees no false edge
            ui_in = '0;
            w = rand_bits(3);
            pin = w[2:0];
            a = byte_addr(periph_pkg::SLOT_EDGE, periph_pkg::EDGE_REG_COUNT);
            write_reg(byte_addr(periph_pkg::SLOT_EDGE, periph_pkg::EDGE_REG_PIN), {29'h0, pin});
            write_reg(a, rand_bits(32));
            read_check("count cleared", a, 32'h0);
            w = rand_bits(9);
            repeat (w[8:0]) begin
                drive_pin(pin, 1'b1);
                drive_pin(pin, 1'b0);
                m_edge_count = m_edge_count + 8'd1;
            end
            read_check("count", a, read_expect(a, ui_in));
            read_check("pin index", byte_addr(periph_pkg::SLOT_EDGE, periph_pkg::EDGE_REG_PIN),
                       {29'h0, pin});
            push_check("uo_out shows count", {24'h0, pins_expect()}, {24'h0, uo_out});
            write_reg(a, 32'h0);
            read_check("count after clear", a, read_expect(a, ui_in));
            push_check("uo_out after clear", {24'h0, pins_expect()}, {24'h0, uo_out});
        end
        report_test();

        cur_test = "read hold";
        a = full_addr(periph_pkg::SLOT_GPIO, periph_pkg::GPIO_REG_IN);
        repeat (4) begin
            ui_in = rand_byte();
            want = read_expect(a, ui_in);
            start_read(a, d);
            ui_in = ui_in ^ (rand_byte() | 8'h01);
            w = rand_bits(4);
            repeat (w[3:0] + 1) begin
                @(posedge clk);
                #2;
            end
            push_check("data at ready", want, d);
            push_check("data while held", want, data_out);
            finish_read();
            read_check("data after release", a, read_expect(a, ui_in));
        end
        report_test();

        cur_test = "empty slots";
        write_reg(byte_addr(periph_pkg::SLOT_EDGE, periph_pkg::EDGE_REG_COUNT), 32'h0);
        repeat (6) begin
            w = rand_bits(10);
            if (w[3:0] == periph_pkg::SLOT_GPIO)
                w[3:0] = 4'd0;
            a = full_addr(w[3:0], w[9:4]);
            read_check("empty full slot", a, read_expect(a, ui_in));
            write_reg(a, rand_bits(32));
            w = rand_bits(8);
            if (w[3:0] == periph_pkg::SLOT_EDGE)
                w[3:0] = 4'd15;
            a = byte_addr(w[3:0], w[7:4]);
            read_check("empty byte slot", a, read_expect(a, ui_in));
            write_reg(a, rand_bits(32));
            w = rand_bits(9);
            a = {2'b11, w[8:0]};
            read_check("unmapped", a, read_expect(a, ui_in));
            write_reg(a, rand_bits(32));
        end
        a = full_addr(periph_pkg::SLOT_GPIO, periph_pkg::GPIO_REG_OUT);
        read_check("gpio out kept", a, read_expect(a, ui_in));
        for (int i = 0; i < 8; i++) begin
            a = full_addr(periph_pkg::SLOT_GPIO, func_off(3'(i)));
            read_check("select kept", a, read_expect(a, ui_in));
        end
        a = byte_addr(periph_pkg::SLOT_EDGE, periph_pkg::EDGE_REG_PIN);
        read_check("edge pin kept", a, read_expect(a, ui_in));
        a = byte_addr(periph_pkg::SLOT_EDGE, periph_pkg::EDGE_REG_COUNT);
        read_check("edge count kept", a, read_expect(a, ui_in));
        push_check("uo_out kept", {24'h0, pins_expect()}, {24'h0, uo_out});
        report_test();

        $display("checks passed: %0d, checks failed: %0d", pass_count, fail_count);
        if (fail_count == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule

// File: src.f
periph_pkg.sv
periph_bus.sv
gpio_ctrl.sv
edge_counter.sv
periph_top.sv
periph_chk.sv
tb_periph.sv

// File: Makefile
# Verilator build and run of the peripheral wrapper testbench

SRCS := $(shell cat src.f)

.PHONY: all run clean

all: run

obj_dir/Vtb_periph: src.f $(SRCS)
	verilator --binary --timing --assert --top-module tb_periph -f src.f

run: obj_dir/Vtb_periph
	@out="$$(./obj_dir/Vtb_periph)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Verification passed"

clean:
	rm -rf obj_dir
